//--- rtl/exec_pkg.sv
// Shared widths, micro-op encodings and record types for the execute stage.
// Each RTL module imports this package inside its body. Ports use scoped names.

package exec_pkg;

    // Widths --------------------
    localparam int XLEN         = 32;  // Register width
    localparam int REG_ADDR_W   = 5;   // Register address width
    localparam int UOP_W        = 5;   // Micro-op width
    localparam int TRAP_CAUSE_W = 6;   // Trap cause carried in operand B

    // One-hot functional unit select
    typedef struct packed {
        logic csr;                     // CSR access
        logic cfu;                     // Control flow
        logic lsu;                     // Load/store
        logic alu;                     // Integer ALU
    } fu_t;

    // ALU view of the micro-op
    typedef enum logic [UOP_W-1:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_XOR  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_AND  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_ROR  = 5'd8,
        ALU_SLT  = 5'd9,
        ALU_SLTU = 5'd10
    } alu_uop_e;

    // Control flow classes and operations --------------------
    localparam logic [1:0] CFU_CLASS_COND   = 2'b00;
    localparam logic [1:0] CFU_CLASS_UNCOND = 2'b10;

    localparam logic [2:0] CFU_BEQ  = 3'd0;  // Conditional ops
    localparam logic [2:0] CFU_BNE  = 3'd1;
    localparam logic [2:0] CFU_BLT  = 3'd2;
    localparam logic [2:0] CFU_BGE  = 3'd3;
    localparam logic [2:0] CFU_BLTU = 3'd4;
    localparam logic [2:0] CFU_BGEU = 3'd5;

    localparam logic [2:0] CFU_JMP  = 3'd0;  // Unconditional ops
    localparam logic [2:0] CFU_JALI = 3'd1;
    localparam logic [2:0] CFU_JALR = 3'd2;

    // Resolved branch codes sent on to the next stage
    localparam logic [UOP_W-1:0] CFU_TAKEN     = 5'b11_001;
    localparam logic [UOP_W-1:0] CFU_NOT_TAKEN = 5'b11_000;

    typedef struct packed {
        logic [1:0] cls;               // Cond / uncond
        logic [2:0] op;                // Operation within class
    } cfu_view_t;

    typedef struct packed {
        logic       load;              // Load access
        logic       store;             // Store access
        logic [2:0] size;              // Access size and sign
    } lsu_view_t;

    // One micro-op word, read differently by each unit
    typedef union packed {
        logic [UOP_W-1:0] raw;
        alu_uop_e         alu;
        cfu_view_t        cfu;
        lsu_view_t        lsu;
    } uop_u;

    // Stage records --------------------
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;     // Destination register
        logic [XLEN-1:0]       opr_a;
        logic [XLEN-1:0]       opr_b;
        logic [XLEN-1:0]       opr_c;
        uop_u                  uop;
        fu_t                   fu;
        logic                  trap;   // Trap raised upstream
        logic [1:0]            size;   // Instruction size
        logic [31:0]           instr;  // Instruction word
    } exec_in_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       opr_a;
        logic [XLEN-1:0]       opr_b;
        uop_u                  uop;
        fu_t                   fu;
        logic                  trap;
        logic [1:0]            size;
        logic [31:0]           instr;
    } exec_out_t;

    // Same-cycle forwarding toward decode
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;  // ALU result or zero
        logic                  load;   // Load in flight
        logic                  csr;    // CSR op in flight
    } fwd_t;

endpackage

//--- rtl/exec_alu.sv
// Single-cycle integer ALU of the execute stage.
// Produces the operation result plus the raw sum and compare flags,
// which the branch unit and load/store addressing share.

`timescale 1ns/1ps

module exec_alu (
    input  exec_pkg::fu_t              i_fu,          // Unit select
    input  exec_pkg::uop_u             i_uop,         // Micro-op word
    input  logic [exec_pkg::XLEN-1:0]  i_opr_a,       // Left operand
    input  logic [exec_pkg::XLEN-1:0]  i_opr_b,       // Right operand
    output logic [exec_pkg::XLEN-1:0]  o_result,      // Zero unless ALU selected
    output logic [exec_pkg::XLEN-1:0]  o_sum,         // Always A + B
    output logic                       o_lt_signed,   // A < B signed
    output logic                       o_lt_unsigned, // A < B unsigned
    output logic                       o_eq           // A == B
);

    import exec_pkg::*;

    // Shared datapath --------------------
    logic [4:0]        shamt;                         // Low 5 bits of B
    logic [XLEN-1:0]   diff;
    logic [XLEN-1:0]   shl;
    logic [XLEN-1:0]   shr_l;
    logic [XLEN-1:0]   shr_a;
    logic [2*XLEN-1:0] rot_wide;                      // A doubled for rotate
    logic [XLEN-1:0]   op_result;

    assign shamt    = i_opr_b[4:0];
    assign o_sum    = i_opr_a + i_opr_b;
    assign diff     = i_opr_a - i_opr_b;

    assign shl      = i_opr_a << shamt;
    assign shr_l    = i_opr_a >> shamt;
    assign shr_a    = $signed(i_opr_a) >>> shamt;      // Sign fill
    assign rot_wide = {i_opr_a, i_opr_a} >> shamt;     // Wraps low bits into top

    // Flags used by SLT/SLTU and by branches
    assign o_lt_signed   = $signed(i_opr_a) < $signed(i_opr_b);
    assign o_lt_unsigned = i_opr_a < i_opr_b;
    assign o_eq          = (i_opr_a == i_opr_b);

    // Operation select --------------------
    always_comb begin
        case (i_uop.alu)
            ALU_ADD:  op_result = o_sum;
            ALU_SUB:  op_result = diff;
            ALU_XOR:  op_result = i_opr_a ^ i_opr_b;
            ALU_OR:   op_result = i_opr_a | i_opr_b;
            ALU_AND:  op_result = i_opr_a & i_opr_b;
            ALU_SLL:  op_result = shl;
            ALU_SRL:  op_result = shr_l;
            ALU_SRA:  op_result = shr_a;
            ALU_ROR:  op_result = rot_wide[XLEN-1:0];
            ALU_SLT:  op_result = {{(XLEN-1){1'b0}}, o_lt_signed};
            ALU_SLTU: op_result = {{(XLEN-1){1'b0}}, o_lt_unsigned};
            default:  op_result = '0;                  // Unused codes
        endcase
    end

    // Keeps forwarding OR clean for other units
    assign o_result = i_fu.alu ? op_result : '0;

endmodule

//--- rtl/exec_branch.sv
// Control flow resolution for the execute stage.
// Conditional branches are rewritten to taken / not-taken codes, and the
// jump or branch target is formed with bit 0 cleared.

`timescale 1ns/1ps

module exec_branch (
    input  exec_pkg::fu_t              i_fu,
    input  exec_pkg::uop_u             i_uop,
    input  logic [exec_pkg::XLEN-1:0]  i_opr_c,        // Precomputed target
    input  logic [exec_pkg::XLEN-1:0]  i_sum,          // rs1 + imm for jalr
    input  logic                       i_lt_signed,
    input  logic                       i_lt_unsigned,
    input  logic                       i_eq,
    output exec_pkg::uop_u             o_uop,          // Rewritten micro-op
    output logic [exec_pkg::XLEN-1:0]  o_target        // Jump / branch target
);

    import exec_pkg::*;

    logic is_cond;                                     // Conditional class
    logic is_jalr;                                     // Register-indirect jump
    logic taken;

    assign is_cond = i_fu.cfu && (i_uop.cfu.cls == CFU_CLASS_COND);
    assign is_jalr = i_fu.cfu && (i_uop.cfu.cls == CFU_CLASS_UNCOND) &&
                     (i_uop.cfu.op == CFU_JALR);

    // Per-op compare rule
    always_comb begin
        case (i_uop.cfu.op)
            CFU_BEQ:  taken = i_eq;
            CFU_BNE:  taken = !i_eq;
            CFU_BLT:  taken = i_lt_signed;
            CFU_BGE:  taken = !i_lt_signed;
            CFU_BLTU: taken = i_lt_unsigned;
            CFU_BGEU: taken = !i_lt_unsigned;
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        o_uop = i_uop;                                 // Pass through by default
        if (is_cond) begin
            o_uop.raw = taken ? CFU_TAKEN : CFU_NOT_TAKEN;
        end
    end

    // Halfword aligned target
    assign o_target = is_jalr ? {i_sum[XLEN-1:1], 1'b0}
                              : {i_opr_c[XLEN-1:1], 1'b0};

endmodule

//--- rtl/exec_result_mux.sv
// Builds the next-stage record from the unit results.
// Operands are chosen by the one-hot unit select, a trap cause replaces
// operand B, and the same-cycle forwarding record is formed here.

`timescale 1ns/1ps

module exec_result_mux (
    input  exec_pkg::exec_in_t         i_s2,           // Decoded instruction
    input  logic [exec_pkg::XLEN-1:0]  i_alu_result,   // Zero when not ALU
    input  logic [exec_pkg::XLEN-1:0]  i_sum,          // Effective address
    input  logic [exec_pkg::XLEN-1:0]  i_target,       // Control flow target
    input  exec_pkg::uop_u             i_cfu_uop,      // Resolved micro-op
    output exec_pkg::exec_out_t        o_next,         // Into pipeline register
    output exec_pkg::fwd_t             o_fwd           // Same-cycle forwarding
);

    import exec_pkg::*;

    logic [XLEN-1:0]         opr_a_sel;
    logic [XLEN-1:0]         opr_b_sel;
    logic [TRAP_CAUSE_W-1:0] trap_cause;

    // Operand A --------------------
    assign opr_a_sel = ({XLEN{i_s2.fu.alu}} & i_alu_result) |
                       ({XLEN{i_s2.fu.lsu}} & i_sum)        |
                       ({XLEN{i_s2.fu.cfu}} & i_target)     |
                       ({XLEN{i_s2.fu.csr}} & i_s2.opr_a);

    // Operand B --------------------
    // ALU and CFU leave it zero; store data or CSR value otherwise
    assign opr_b_sel = {XLEN{i_s2.fu.lsu | i_s2.fu.csr}} & i_s2.opr_c;

    assign trap_cause = {{(TRAP_CAUSE_W-REG_ADDR_W){1'b0}}, i_s2.rd};  // Cause in rd

    always_comb begin
        o_next.rd    = i_s2.rd;
        o_next.opr_a = opr_a_sel;
        o_next.opr_b = i_s2.trap ? {{(XLEN-TRAP_CAUSE_W){1'b0}}, trap_cause}
                                 : opr_b_sel;
        o_next.uop   = i_cfu_uop;                      // Non-CFU ops unchanged
        o_next.fu    = i_s2.fu;
        o_next.trap  = i_s2.trap;
        o_next.size  = i_s2.size;
        o_next.instr = i_s2.instr;
    end

    // Forwarding --------------------
    always_comb begin
        o_fwd.rd    = i_s2.rd;
        o_fwd.wdata = i_alu_result;
        o_fwd.load  = i_s2.fu.lsu && i_s2.uop.lsu.load;  // Result not ready yet
        o_fwd.csr   = i_s2.fu.csr;
    end

endmodule

//--- rtl/exec_pipe_reg.sv
// One-deep pipeline register between execute and the next stage.
// Holds one item under back-pressure and reloads in the cycle it is taken.

`timescale 1ns/1ps

module exec_pipe_reg #(
    parameter int RLEN = 32                            // Record width
) (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            i_flush,                   // Drop held item
    input  logic [RLEN-1:0] i_data,                    // From this stage
    input  logic            i_valid,
    output logic            o_busy,                    // Back to producer
    output logic [RLEN-1:0] o_data,                    // To next stage
    output logic            o_valid,
    input  logic            i_busy                     // From next stage
);

    logic accept;

    // Full and blocked
    assign o_busy = o_valid && i_busy;
    assign accept = i_valid && !o_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;                           // Flush beats load
        end else if (!o_busy) begin
            o_valid <= i_valid;                        // Empty or just taken
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept && !i_flush) begin
            o_data <= i_data;
        end
    end

endmodule

//--- rtl/exec_stage.sv
// Top of the execute stage. ALU, branch resolution and result select run in
// one cycle, then the record is registered toward the next stage.
// Forwarding information is driven combinationally from the input.

`timescale 1ns/1ps

module exec_stage (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_flush,
    input  exec_pkg::exec_in_t    i_s2,                // From decode
    input  logic                  i_s2_valid,
    output logic                  o_s2_busy,
    output exec_pkg::exec_out_t   o_s3,                // To next stage
    output logic                  o_s3_valid,
    input  logic                  i_s3_busy,
    output exec_pkg::fwd_t        o_fwd
);

    import exec_pkg::*;

    // Unit outputs --------------------
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] alu_sum;
    logic            lt_signed;
    logic            lt_unsigned;
    logic            eq;
    uop_u            cfu_uop;
    logic [XLEN-1:0] cfu_target;
    exec_out_t       next_rec;                         // Pipeline register input

    exec_alu u_alu (
        .i_fu          (i_s2.fu),
        .i_uop         (i_s2.uop),
        .i_opr_a       (i_s2.opr_a),
        .i_opr_b       (i_s2.opr_b),
        .o_result      (alu_result),
        .o_sum         (alu_sum),
        .o_lt_signed   (lt_signed),
        .o_lt_unsigned (lt_unsigned),
        .o_eq          (eq)
    );

    exec_branch u_branch (
        .i_fu          (i_s2.fu),
        .i_uop         (i_s2.uop),
        .i_opr_c       (i_s2.opr_c),
        .i_sum         (alu_sum),
        .i_lt_signed   (lt_signed),
        .i_lt_unsigned (lt_unsigned),
        .i_eq          (eq),
        .o_uop         (cfu_uop),
        .o_target      (cfu_target)
    );

    exec_result_mux u_mux (
        .i_s2          (i_s2),
        .i_alu_result  (alu_result),
        .i_sum         (alu_sum),
        .i_target      (cfu_target),
        .i_cfu_uop     (cfu_uop),
        .o_next        (next_rec),
        .o_fwd         (o_fwd)
    );

    exec_pipe_reg #(
        .RLEN ($bits(exec_out_t))
    ) u_pipe_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_flush  (i_flush),
        .i_data   (next_rec),
        .i_valid  (i_s2_valid),
        .o_busy   (o_s2_busy),
        .o_data   (o_s3),
        .o_valid  (o_s3_valid),
        .i_busy   (i_s3_busy)
    );

endmodule

//--- test/exec_stage_asserts.sv
// Concurrent checks on the execute stage handshake and reset, bound into
// exec_stage. The testbench reads the failure count at the end of the run.

`timescale 1ns/1ps

module exec_stage_asserts (
    input logic                 g_clk,
    input logic                 g_resetn,
    input logic                 i_flush,
    input exec_pkg::exec_out_t  i_s3,                  // DUT output record
    input logic                 i_s3_valid,
    input logic                 i_s2_busy,
    input logic                 i_s3_busy
);

    int n_fail = 0;                                    // Read by the testbench

    // Held record stays put under back-pressure
    a_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (i_s3_valid && i_s3_busy && !i_flush) |=> (i_s3_valid && $stable(i_s3)))
        else begin
            $error("output record changed while valid and blocked");
            n_fail++;
        end

    // Busy only when full and blocked
    a_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_s2_busy == (i_s3_valid && i_s3_busy))
        else begin
            $error("busy does not match valid and next-stage busy");
            n_fail++;
        end

    a_clear: assert property (@(posedge g_clk) (!g_resetn || i_flush) |=> !i_s3_valid)
        else begin
            $error("valid still high after reset or flush");
            n_fail++;
        end

endmodule

bind exec_stage exec_stage_asserts u_asserts (
    .g_clk      (g_clk),
    .g_resetn   (g_resetn),
    .i_flush    (i_flush),
    .i_s3       (o_s3),
    .i_s3_valid (o_s3_valid),
    .i_s2_busy  (o_s2_busy),
    .i_s3_busy  (i_s3_busy)
);

//--- test/tb_exec_stage.sv
// Testbench for the execute stage. Drives random decoded instructions from an
// xorshift generator, predicts each record from the unit rules and checks
// outputs, forwarding and the handshake once per cycle in four test phases.

`timescale 1ns/1ps

module tb_exec_stage;

    import exec_pkg::*;

    localparam int N_ITEMS   = 400;                    // Items over all phases
    localparam int PHASE_LEN = N_ITEMS / 4;
    localparam int CYC_LIMIT = N_ITEMS * 8 + 100;      // Worst case with stalls

    logic        g_clk;
    logic        g_resetn;
    logic        i_flush;
    exec_in_t    i_s2;
    logic        i_s2_valid;
    logic        o_s2_busy;
    exec_out_t   o_s3;
    logic        o_s3_valid;
    logic        i_s3_busy;
    fwd_t        o_fwd;

    logic [31:0] rng;                                  // xorshift state
    int          cycles;
    int          errors;
    int          checks;
    int          n_accepted;                           // Per phase
    int          asrt_fail;
    logic        hold;                                 // Producer holding i_s2
    exec_out_t   expect_q[$];                          // Mirrors pipeline register

    exec_stage UUT (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_flush    (i_flush),
        .i_s2       (i_s2),
        .i_s2_valid (i_s2_valid),
        .o_s2_busy  (o_s2_busy),
        .o_s3       (o_s3),
        .o_s3_valid (o_s3_valid),
        .i_s3_busy  (i_s3_busy),
        .o_fwd      (o_fwd)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;                     // 4 ns period
    end

    initial begin
        cycles = 0;
        while (cycles < CYC_LIMIT) begin
            @(posedge g_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not finish", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    // Stimulus --------------------
    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // One-hot unit from mask, valid code for that unit, random fields
    function automatic exec_in_t random_instr(input logic [3:0] mask);
        exec_in_t    ins;
        logic [31:0] r;
        logic [1:0]  pick;
        r = next_random();
        pick = r[1:0];
        while (!mask[pick]) begin
            r = next_random();
            pick = r[1:0];
        end
        ins.fu = fu_t'(4'b0001 << pick);               // alu, lsu, cfu, csr
        case (pick)
            2'd0: ins.uop.raw = 5'(r[15:8] % 8'd11);
            2'd1: begin
                ins.uop.lsu.load  = r[8];
                ins.uop.lsu.store = ~r[8];
                ins.uop.lsu.size  = r[11:9];
            end
            2'd2: begin
                if (r[8]) begin
                    ins.uop.cfu.cls = CFU_CLASS_COND;
                    ins.uop.cfu.op  = 3'(r[15:12] % 4'd6);
                end else begin
                    ins.uop.cfu.cls = CFU_CLASS_UNCOND;
                    ins.uop.cfu.op  = 3'(r[15:12] % 4'd3);
                end
            end
            default: ins.uop.raw = r[12:8];            // CSR code passes through
        endcase
        ins.rd    = r[20:16];
        ins.trap  = (r[24:21] == 4'd0);                // About 1 in 16
        ins.size  = r[26:25];
        ins.opr_a = next_random();
        ins.opr_b = (r[29:27] == 3'd0) ? ins.opr_a : next_random();  // Some equal pairs
        ins.opr_c = next_random();
        ins.instr = next_random();
        return ins;
    endfunction

    // Reference model --------------------
    function automatic logic [XLEN-1:0] alu_model(input exec_in_t ins);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [4:0]      sh;
        a = ins.opr_a;
        b = ins.opr_b;
        sh = b[4:0];                                   // Amount masked to 5 bits
        if (!ins.fu.alu) begin
            return '0;
        end
        case (ins.uop.alu)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | ({XLEN{a[31]}} & ~({XLEN{1'b1}} >> sh));
            ALU_ROR:  return (a >> sh) | (a << (6'd32 - {1'b0, sh}));
            ALU_SLT:  return {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            ALU_SLTU: return {{(XLEN-1){1'b0}}, (a < b)};
            default:  return '0;
        endcase
    endfunction

    function automatic exec_out_t predict(input exec_in_t ins);
        exec_out_t       o;
        logic [XLEN-1:0] sum;
        logic            take;
        sum = ins.opr_a + ins.opr_b;
        take = 1'b0;
        o.rd = ins.rd;
        o.uop = ins.uop;
        o.fu = ins.fu;
        o.trap = ins.trap;
        o.size = ins.size;
        o.instr = ins.instr;
        o.opr_b = '0;                                  // ALU and CFU
        if (ins.fu.alu) begin
            o.opr_a = alu_model(ins);
        end else if (ins.fu.lsu) begin
            o.opr_a = sum;                             // Effective address
            o.opr_b = ins.opr_c;                       // Store data
        end else if (ins.fu.cfu) begin
            if (ins.uop.cfu.cls == CFU_CLASS_UNCOND && ins.uop.cfu.op == CFU_JALR) begin
                o.opr_a = {sum[XLEN-1:1], 1'b0};
            end else begin
                o.opr_a = {ins.opr_c[XLEN-1:1], 1'b0};
            end
            if (ins.uop.cfu.cls == CFU_CLASS_COND) begin
                case (ins.uop.cfu.op)
                    CFU_BEQ:  take = (ins.opr_a == ins.opr_b);
                    CFU_BNE:  take = (ins.opr_a != ins.opr_b);
                    CFU_BLT:  take = ($signed(ins.opr_a) < $signed(ins.opr_b));
                    CFU_BGE:  take = !($signed(ins.opr_a) < $signed(ins.opr_b));
                    CFU_BLTU: take = (ins.opr_a < ins.opr_b);
                    CFU_BGEU: take = (ins.opr_a >= ins.opr_b);
                    default:  take = 1'b0;
                endcase
                o.uop.raw = take ? CFU_TAKEN : CFU_NOT_TAKEN;
            end
        end else begin
            o.opr_a = ins.opr_a;                       // CSR pass-through
            o.opr_b = ins.opr_c;
        end
        if (ins.trap) begin
            o.opr_b = {{(XLEN-REG_ADDR_W){1'b0}}, ins.rd};  // Cause from rd
        end
        return o;
    endfunction

    function automatic fwd_t fwd_model(input exec_in_t ins);
        fwd_t f;
        f.rd    = ins.rd;
        f.wdata = alu_model(ins);                      // Zero for other units
        f.load  = ins.fu.lsu && ins.uop.lsu.load;
        f.csr   = ins.fu.csr;
        return f;
    endfunction

    // Checking --------------------
    task automatic compare(input string test, input string what,
                           input logic [127:0] expv, input logic [127:0] actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("Fail %s %s: expected %h actual %h", test, what, expv, actv);
        end
    endtask

    // One cycle: drive after the edge, check mid-cycle, model the next edge
    task automatic step(input string test, input logic [3:0] mask,
                        input logic use_flush, input logic idle);
        logic [31:0] r;
        logic        busy_exp;
        @(posedge g_clk);
        #1;
        r = next_random();
        if (idle) begin
            i_s2_valid = 1'b0;
            i_s3_busy  = 1'b0;
            i_flush    = 1'b0;
        end else begin
            if (!hold) begin
                i_s2_valid = (r[2:0] != 3'd0);         // Mostly valid
                i_s2       = random_instr(mask);
            end
            i_s3_busy = ((r[31:16] % 16'd3) == 16'd0); // About a third
            i_flush   = use_flush && (r[13:8] == 6'd0);
        end
        @(negedge g_clk);
        busy_exp = (expect_q.size() != 0) && i_s3_busy;
        compare(test, "o_fwd", 128'(fwd_model(i_s2)), 128'(o_fwd));
        compare(test, "o_s2_busy", 128'(busy_exp), 128'(o_s2_busy));
        compare(test, "o_s3_valid", 128'(expect_q.size() != 0), 128'(o_s3_valid));
        if (o_s3_valid && expect_q.size() != 0) begin
            compare(test, "o_s3", 128'(expect_q[0]), 128'(o_s3));  // Also while held
        end
        if (o_s3_valid && !i_s3_busy && expect_q.size() != 0) begin
            void'(expect_q.pop_front());               // Taken at the edge
        end
        if (i_flush) begin
            expect_q.delete();                         // Held and incoming dropped
        end else if (i_s2_valid && !o_s2_busy) begin
            expect_q.push_back(predict(i_s2));
        end
        if (i_s2_valid && !o_s2_busy) begin
            n_accepted++;
        end
        hold = i_s2_valid && o_s2_busy;
    endtask

    task automatic run_phase(input string test, input logic [3:0] mask,
                             input logic use_flush);
        int errs_before;
        errs_before = errors;
        n_accepted = 0;
        while (n_accepted < PHASE_LEN) begin
            step(test, mask, use_flush, 1'b0);
        end
        $display("%s: %0d items accepted, %0d errors", test, n_accepted,
                 errors - errs_before);
    endtask

    initial begin
        rng        = 32'd52490;
        errors     = 0;
        checks     = 0;
        n_accepted = 0;
        hold       = 1'b0;
        g_resetn   = 1'b0;
        i_flush    = 1'b0;
        i_s2       = '0;
        i_s2_valid = 1'b0;
        i_s3_busy  = 1'b0;
        repeat (5) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;
        @(negedge g_clk);
        compare("reset", "o_s3_valid", 128'(1'b0), 128'(o_s3_valid));
        compare("reset", "o_s2_busy", 128'(1'b0), 128'(o_s2_busy));
        $display("reset: %0d errors", errors);

        run_phase("alu_ops", 4'b0001, 1'b0);
        run_phase("branch", 4'b0100, 1'b0);
        run_phase("lsu_csr_trap", 4'b1010, 1'b0);
        run_phase("mixed_flush", 4'b1111, 1'b1);
        while (expect_q.size() != 0 || hold) begin
            step("drain", 4'b1111, 1'b0, 1'b1);        // Empty the register
        end
        step("drain", 4'b1111, 1'b0, 1'b1);

        asrt_fail = UUT.u_asserts.n_fail;
        $display("Checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, asrt_fail);
        if (errors == 0 && asrt_fail == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
rtl/exec_pkg.sv
rtl/exec_alu.sv
rtl/exec_branch.sv
rtl/exec_result_mux.sv
rtl/exec_pipe_reg.sv
rtl/exec_stage.sv
test/exec_stage_asserts.sv
test/tb_exec_stage.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

BUILD := obj_dir
LOG   := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_exec_stage -Mdir $(BUILD) -f sim.f

run: compile
	./$(BUILD)/Vtb_exec_stage +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)
	! grep -q "RESULT: FAIL" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
